/* rtl/rv_core_pkg.sv */
package rv_core_pkg;

    //////////////////////////////////////////////////
    // widths and reset state
    //////////////////////////////////////////////////
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [XLEN-1:0] RESET_PC = '0;

    //////////////////////////////////////////////////
    // rv32i major opcodes
    //////////////////////////////////////////////////
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    //////////////////////////////////////////////////
    // stage payloads
    //////////////////////////////////////////////////
    typedef struct packed {
        word_t pc;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        word_t     pc;
        word_t     rs1_data;
        word_t     rs2_data;
        word_t     imm;
        reg_addr_t rd;
        logic      we;
        alu_op_e   alu_op;
        logic      sel_pc;
        logic      sel_imm;
        logic [2:0] funct3;
        logic      branch;
        logic      jal;
        logic      jalr;
        logic      load;
        logic      store;
        logic      lui;
    } id_ex_t;

    typedef struct packed {
        reg_addr_t rd;
        logic      we;
        word_t     data;
    } ex_wb_t;

endpackage

/* rtl/pipe_stage.sv */
module pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     reset_i,
    input  logic     valid_i,
    input  payload_t data_i,
    input  logic     cancel_i,
    input  logic     ready_go_i,
    input  logic     allow_in_i,
    output logic     allow_in_o,
    output logic     valid_o,
    output payload_t data_o
);

    // empty, or the current item moves on this cycle
    assign allow_in_o = !valid_o || (ready_go_i && allow_in_i);

    always_ff @(posedge clk_i) begin
        if (reset_i || cancel_i) begin
            valid_o <= 1'b0;
        end else if (allow_in_o) begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i && allow_in_o) begin
            data_o <= data_i;
        end
    end

endmodule

/* rtl/fetch_unit.sv */
module fetch_unit import rv_core_pkg::*; (
    input  logic   clk_i,
    input  logic   reset_i,
    input  logic   redirect_i,
    input  word_t  redirect_pc_i,
    input  logic   allow_in_i,
    input  logic   rom_ok_i,
    input  word_t  rom_rdata_i,
    output logic   rom_req_o,
    output word_t  rom_addr_o,
    output logic   valid_o,
    output if_id_t fetch_o
);

    word_t  pc_q;
    logic   drop_q;
    logic   buf_valid_q;
    if_id_t buf_q;
    if_id_t resp_item;
    logic   resp_use;
    logic   can_issue;
    word_t  issue_pc;

    // response of the outstanding request, unless a redirect made it stale
    assign resp_use  = rom_req_o && rom_ok_i && !drop_q;
    assign resp_item = '{pc: rom_addr_o, instr: rom_rdata_i};

    assign valid_o = buf_valid_q || resp_use;
    assign fetch_o = buf_valid_q ? buf_q : resp_item;

    // one request at a time and nothing left waiting for IF/ID
    assign can_issue = (!rom_req_o || rom_ok_i) && (!valid_o || allow_in_i || redirect_i);
    assign issue_pc  = redirect_i ? redirect_pc_i : pc_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pc_q      <= RESET_PC;
            rom_req_o <= 1'b0;
        end else if (can_issue) begin
            pc_q      <= issue_pc + 32'd4;
            rom_req_o <= 1'b1;
        end else begin
            if (redirect_i) begin
                pc_q <= redirect_pc_i;
            end
            if (rom_ok_i) begin
                rom_req_o <= 1'b0;
            end
        end
    end

    // address stays put while the request waits
    always_ff @(posedge clk_i) begin
        if (can_issue) begin
            rom_addr_o <= issue_pc;
        end
    end

    ///////////////////////////////////////////////////
    // stale response drop and one-entry hold buffer
    ///////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            drop_q <= 1'b0;
        end else if (rom_req_o && rom_ok_i) begin
            drop_q <= 1'b0;
        end else if (rom_req_o && redirect_i) begin
            drop_q <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i || redirect_i) begin
            buf_valid_q <= 1'b0;
        end else if (resp_use && !allow_in_i) begin
            buf_valid_q <= 1'b1;
        end else if (allow_in_i) begin
            buf_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (resp_use && !allow_in_i) begin
            buf_q <= resp_item;
        end
    end

endmodule

/* rtl/decoder.sv */
module decoder import rv_core_pkg::*; (
    input  if_id_t    fetch_i,
    input  word_t     rs1_data_i,
    input  word_t     rs2_data_i,
    output reg_addr_t rs1_o,
    output reg_addr_t rs2_o,
    output logic      uses_rs1_o,
    output logic      uses_rs2_o,
    output id_ex_t    work_o
);

    word_t      instr;
    logic [6:0] opcode;
    logic [6:0] funct7;
    logic [2:0] funct3;
    word_t      imm_i, imm_s, imm_b, imm_u, imm_j;
    alu_op_e    arith_op;

    assign instr  = fetch_i.instr;
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rs1_o  = instr[19:15];
    assign rs2_o  = instr[24:20];

    assign uses_rs1_o = opcode inside {OPC_JALR, OPC_BRANCH, OPC_LOAD, OPC_STORE,
                                       OPC_OP_IMM, OPC_OP};
    assign uses_rs2_o = opcode inside {OPC_BRANCH, OPC_STORE, OPC_OP};

    //////////////////////////////////////////////////
    // immediates
    //////////////////////////////////////////////////
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // funct7 bit 5 picks sub and sra; sub only exists in register form
    always_comb begin
        unique case (funct3)
            3'b000:  arith_op = (opcode == OPC_OP && funct7[5]) ? ALU_SUB : ALU_ADD;
            3'b001:  arith_op = ALU_SLL;
            3'b010:  arith_op = ALU_SLT;
            3'b011:  arith_op = ALU_SLTU;
            3'b100:  arith_op = ALU_XOR;
            3'b101:  arith_op = funct7[5] ? ALU_SRA : ALU_SRL;
            3'b110:  arith_op = ALU_OR;
            default: arith_op = ALU_AND;
        endcase
    end

    always_comb begin
        work_o          = '0;
        work_o.pc       = fetch_i.pc;
        work_o.rs1_data = rs1_data_i;
        work_o.rs2_data = rs2_data_i;
        work_o.rd       = instr[11:7];
        work_o.funct3   = funct3;
        work_o.alu_op   = ALU_ADD;
        unique case (opcode)
            OPC_LUI: begin
                work_o.we     = 1'b1;
                work_o.lui    = 1'b1;
                work_o.imm    = imm_u;
                work_o.alu_op = ALU_PASS_B;
            end
            OPC_AUIPC: begin
                work_o.we      = 1'b1;
                work_o.sel_pc  = 1'b1;
                work_o.sel_imm = 1'b1;
                work_o.imm     = imm_u;
            end
            OPC_JAL: begin
                work_o.we     = 1'b1;
                work_o.jal    = 1'b1;
                work_o.sel_pc = 1'b1;
                work_o.imm    = imm_j;
            end
            OPC_JALR: begin
                work_o.we     = 1'b1;
                work_o.jalr   = 1'b1;
                work_o.sel_pc = 1'b1;
                work_o.imm    = imm_i;
            end
            OPC_BRANCH: begin
                work_o.branch = 1'b1;
                work_o.imm    = imm_b;
            end
            OPC_LOAD: begin
                work_o.we      = 1'b1;
                work_o.load    = 1'b1;
                work_o.sel_imm = 1'b1;
                work_o.imm     = imm_i;
            end
            OPC_STORE: begin
                work_o.store   = 1'b1;
                work_o.sel_imm = 1'b1;
                work_o.imm     = imm_s;
            end
            OPC_OP_IMM: begin
                work_o.we      = 1'b1;
                work_o.sel_imm = 1'b1;
                work_o.imm     = imm_i;
                work_o.alu_op  = arith_op;
            end
            OPC_OP: begin
                work_o.we     = 1'b1;
                work_o.alu_op = arith_op;
            end
            // anything else runs as a bubble
            default: ;
        endcase
    end

endmodule

/* rtl/regfile_bypass.sv */
module regfile_bypass import rv_core_pkg::*; (
    input  logic      clk_i,
    input  logic      reset_i,
    input  reg_addr_t rs1_i,
    input  reg_addr_t rs2_i,
    input  logic      uses_rs1_i,
    input  logic      uses_rs2_i,
    input  ex_wb_t    wb_i,
    input  logic      wb_valid_i,
    input  reg_addr_t ex_rd_i,
    input  logic      ex_we_i,
    input  logic      ex_valid_i,
    input  logic      ex_done_i,
    input  word_t     ex_data_i,
    output word_t     rs1_data_o,
    output word_t     rs2_data_o,
    output logic      stall_o
);

    word_t regs [1:31];
    logic  wr_en;
    logic  ex_writes;

    assign wr_en     = wb_valid_i && wb_i.we && (wb_i.rd != '0);
    assign ex_writes = ex_valid_i && ex_we_i && (ex_rd_i != '0);

    always_ff @(posedge clk_i) begin
        if (wr_en && !reset_i) begin
            regs[wb_i.rd] <= wb_i.data;
        end
    end

    // newest source first from execute through write back to the array
    function automatic word_t read_port(reg_addr_t ra);
        word_t val;
        if (ra == '0) begin
            val = '0;
        end else if (ex_writes && ex_done_i && ex_rd_i == ra) begin
            val = ex_data_i;
        end else if (wr_en && wb_i.rd == ra) begin
            val = wb_i.data;
        end else begin
            val = regs[ra];
        end
        return val;
    endfunction

    always_comb begin
        rs1_data_o = read_port(rs1_i);
        rs2_data_o = read_port(rs2_i);
    end

    // load in execute still waiting on its data
    assign stall_o = ex_writes && !ex_done_i &&
                     ((uses_rs1_i && ex_rd_i == rs1_i) || (uses_rs2_i && ex_rd_i == rs2_i));

endmodule

/* rtl/execute_unit.sv */
module execute_unit import rv_core_pkg::*; (
    input  logic   valid_i,
    input  id_ex_t work_i,
    input  logic   ram_ok_i,
    input  word_t  ram_rdata_i,
    output logic   ready_go_o,
    output ex_wb_t result_o,
    output logic   redirect_o,
    output word_t  redirect_pc_o,
    output logic   ram_req_o,
    output logic   ram_we_o,
    output word_t  ram_addr_o,
    output word_t  ram_wdata_o
);

    logic  mem_op;
    logic  jump;
    logic  taken;
    word_t op_a;
    word_t op_b;
    word_t alu_out;
    word_t target;

    assign mem_op = work_i.load || work_i.store;
    assign jump   = work_i.jal || work_i.jalr;

    //////////////////////////////////////////////////
    // alu
    //////////////////////////////////////////////////
    // jumps add 4 to pc for the link value
    assign op_a = work_i.sel_pc ? work_i.pc : work_i.rs1_data;
    assign op_b = jump ? 32'd4 :
                  (work_i.sel_imm || work_i.lui) ? work_i.imm : work_i.rs2_data;

    always_comb begin
        unique case (work_i.alu_op)
            ALU_ADD:    alu_out = op_a + op_b;
            ALU_SUB:    alu_out = op_a - op_b;
            ALU_SLL:    alu_out = op_a << op_b[4:0];
            ALU_SLT:    alu_out = word_t'($signed(op_a) < $signed(op_b));
            ALU_SLTU:   alu_out = word_t'(op_a < op_b);
            ALU_XOR:    alu_out = op_a ^ op_b;
            ALU_SRL:    alu_out = op_a >> op_b[4:0];
            ALU_SRA:    alu_out = word_t'($signed(op_a) >>> op_b[4:0]);
            ALU_OR:     alu_out = op_a | op_b;
            ALU_AND:    alu_out = op_a & op_b;
            ALU_PASS_B: alu_out = op_b;
            default:    alu_out = '0;
        endcase
    end

    //////////////////////////////////////////////////
    // branch decision and jump target
    //////////////////////////////////////////////////
    always_comb begin
        unique case (work_i.funct3)
            3'b000:  taken = work_i.rs1_data == work_i.rs2_data;
            3'b001:  taken = work_i.rs1_data != work_i.rs2_data;
            3'b100:  taken = $signed(work_i.rs1_data) < $signed(work_i.rs2_data);
            3'b101:  taken = $signed(work_i.rs1_data) >= $signed(work_i.rs2_data);
            3'b110:  taken = work_i.rs1_data < work_i.rs2_data;
            3'b111:  taken = work_i.rs1_data >= work_i.rs2_data;
            default: taken = 1'b0;
        endcase
    end

    assign target        = (work_i.jalr ? work_i.rs1_data : work_i.pc) + work_i.imm;
    assign redirect_pc_o = {target[XLEN-1:1], 1'b0};
    assign redirect_o    = valid_i && (jump || (work_i.branch && taken));

    //////////////////////////////////////////////////
    // data memory
    //////////////////////////////////////////////////
    // ID/EX holds the item, so the request stays stable until ram_ok_i
    assign ram_req_o   = valid_i && mem_op;
    assign ram_we_o    = work_i.store;
    assign ram_addr_o  = alu_out;
    assign ram_wdata_o = work_i.rs2_data;

    // write back always takes the result, so the item leaves in its ram_ok_i cycle
    assign ready_go_o = !mem_op || ram_ok_i;

    assign result_o.rd   = work_i.rd;
    assign result_o.we   = work_i.we;
    assign result_o.data = work_i.load ? ram_rdata_i : alu_out;

endmodule

/* rtl/rv_core.sv */
module rv_core import rv_core_pkg::*; (
    input  logic  clk_i,
    input  logic  reset_i,
    output logic  rom_req_o,
    output word_t rom_addr_o,
    input  logic  rom_ok_i,
    input  word_t rom_rdata_i,
    output logic  ram_req_o,
    output logic  ram_we_o,
    output word_t ram_addr_o,
    output word_t ram_wdata_o,
    input  logic  ram_ok_i,
    input  word_t ram_rdata_i
);

    logic      redirect;
    word_t     redirect_pc;

    // fetch
    logic      fetch_valid;
    if_id_t    fetch_item;

    // decode
    logic      id_allow_in;
    logic      id_valid;
    if_id_t    id_item;
    reg_addr_t rs1;
    reg_addr_t rs2;
    logic      uses_rs1;
    logic      uses_rs2;
    word_t     rs1_data;
    word_t     rs2_data;
    logic      stall;
    id_ex_t    id_work;

    // execute and write back
    logic      ex_allow_in;
    logic      ex_valid;
    logic      ex_ready_go;
    id_ex_t    ex_work;
    ex_wb_t    ex_result;
    logic      wb_allow_in;
    logic      wb_valid;
    ex_wb_t    wb_item;

    fetch_unit fetch_unit_inst (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .allow_in_i    (id_allow_in),
        .rom_ok_i      (rom_ok_i),
        .rom_rdata_i   (rom_rdata_i),
        .rom_req_o     (rom_req_o),
        .rom_addr_o    (rom_addr_o),
        .valid_o       (fetch_valid),
        .fetch_o       (fetch_item)
    );

    pipe_stage #(.payload_t(if_id_t)) if_id_reg (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .valid_i    (fetch_valid),
        .data_i     (fetch_item),
        .cancel_i   (redirect),
        .ready_go_i (!stall),
        .allow_in_i (ex_allow_in),
        .allow_in_o (id_allow_in),
        .valid_o    (id_valid),
        .data_o     (id_item)
    );

    decoder decoder_inst (
        .fetch_i    (id_item),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .rs1_o      (rs1),
        .rs2_o      (rs2),
        .uses_rs1_o (uses_rs1),
        .uses_rs2_o (uses_rs2),
        .work_o     (id_work)
    );

    regfile_bypass regfile_bypass_inst (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .rs1_i      (rs1),
        .rs2_i      (rs2),
        .uses_rs1_i (uses_rs1),
        .uses_rs2_i (uses_rs2),
        .wb_i       (wb_item),
        .wb_valid_i (wb_valid),
        .ex_rd_i    (ex_work.rd),
        .ex_we_i    (ex_work.we),
        .ex_valid_i (ex_valid),
        .ex_done_i  (ex_ready_go),
        .ex_data_i  (ex_result.data),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .stall_o    (stall)
    );

    // a stalled decode passes an empty slot into execute
    pipe_stage #(.payload_t(id_ex_t)) id_ex_reg (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .valid_i    (id_valid && !stall),
        .data_i     (id_work),
        .cancel_i   (redirect),
        .ready_go_i (ex_ready_go),
        .allow_in_i (wb_allow_in),
        .allow_in_o (ex_allow_in),
        .valid_o    (ex_valid),
        .data_o     (ex_work)
    );

    execute_unit execute_unit_inst (
        .valid_i       (ex_valid),
        .work_i        (ex_work),
        .ram_ok_i      (ram_ok_i),
        .ram_rdata_i   (ram_rdata_i),
        .ready_go_o    (ex_ready_go),
        .result_o      (ex_result),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc),
        .ram_req_o     (ram_req_o),
        .ram_we_o      (ram_we_o),
        .ram_addr_o    (ram_addr_o),
        .ram_wdata_o   (ram_wdata_o)
    );

    // write back never holds
    pipe_stage #(.payload_t(ex_wb_t)) ex_wb_reg (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .valid_i    (ex_valid && ex_ready_go),
        .data_i     (ex_result),
        .cancel_i   (1'b0),
        .ready_go_i (1'b1),
        .allow_in_i (1'b1),
        .allow_in_o (wb_allow_in),
        .valid_o    (wb_valid),
        .data_o     (wb_item)
    );

endmodule

/* verification/rv_core_props.sv */
module rv_core_props (
    input logic        clk_i,
    input logic        reset_i,
    input logic        rom_req_i,
    input logic [31:0] rom_addr_i,
    input logic        rom_ok_i,
    input logic        ram_req_i,
    input logic        ram_we_i,
    input logic [31:0] ram_addr_i,
    input logic [31:0] ram_wdata_i,
    input logic        ram_ok_i
);

    // both ports idle once reset has been seen
    assert property (@(posedge clk_i) $past(reset_i) |-> !rom_req_i && !ram_req_i)
        else $error("memory request raised during reset");

    //////////////////////////////////////////////////
    // requests hold until their acknowledge
    //////////////////////////////////////////////////
    assert property (@(posedge clk_i) disable iff (reset_i)
        rom_req_i && !rom_ok_i |=> rom_req_i && $stable(rom_addr_i))
        else $error("instruction request changed before its acknowledge");

    assert property (@(posedge clk_i) disable iff (reset_i)
        ram_req_i && !ram_ok_i |=> ram_req_i && $stable(ram_we_i) &&
                                   $stable(ram_addr_i) && $stable(ram_wdata_i))
        else $error("data request changed before its acknowledge");

    // word accesses only
    assert property (@(posedge clk_i) disable iff (reset_i)
        rom_req_i |-> rom_addr_i[1:0] == 2'b00)
        else $error("instruction address not word aligned");

    assert property (@(posedge clk_i) disable iff (reset_i)
        ram_req_i |-> ram_addr_i[1:0] == 2'b00)
        else $error("data address not word aligned");

endmodule

bind rv_core rv_core_props rv_core_props_inst (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .rom_req_i   (rom_req_o),
    .rom_addr_i  (rom_addr_o),
    .rom_ok_i    (rom_ok_i),
    .ram_req_i   (ram_req_o),
    .ram_we_i    (ram_we_o),
    .ram_addr_i  (ram_addr_o),
    .ram_wdata_i (ram_wdata_o),
    .ram_ok_i    (ram_ok_i)
);

/* verification/tb_rv_core.sv */
module tb_rv_core;

    localparam int          RESET_CYCLES = 16;
    localparam int          PROG_LEN     = 64;
    localparam int          MAX_LAT      = 3;
    localparam int          NUM_STORES   = 22;
    localparam logic [31:0] POISON_ADDR  = 32'h200;
    localparam int          WATCHDOG_CYCLES = RESET_CYCLES + PROG_LEN * 8 * MAX_LAT;

    logic        clk_i = 1'b0;
    logic        reset_i;
    logic        rom_req_o;
    logic [31:0] rom_addr_o;
    logic        rom_ok_i;
    logic [31:0] rom_rdata_i;
    logic        ram_req_o;
    logic        ram_we_o;
    logic [31:0] ram_addr_o;
    logic [31:0] ram_wdata_o;
    logic        ram_ok_i;
    logic [31:0] ram_rdata_i;

    logic [31:0] imem [0:255];
    logic [31:0] dmem [0:255];
    logic [31:0] exp_addr [0:NUM_STORES-1];
    logic [31:0] exp_data [0:NUM_STORES-1];
    int          exp_count;
    int          store_idx;
    logic [31:0] lfsr_q;
    logic        rom_busy;
    logic [1:0]  rom_wait;
    logic        ram_busy;
    logic [1:0]  ram_wait;
    logic        ram_ack_store;
    logic        passed;
    logic        fail_printed;

    rv_core rv_core_inst (.*);

    always #2 clk_i = ~clk_i;

    //////////////////////////////////////////////////
    // failure reporting and random latency
    //////////////////////////////////////////////////
    task automatic flag_mismatch(string what, logic [31:0] exp, logic [31:0] act);
        $display("MISMATCH at %0t: %s expected %08h got %08h", $time, what, exp, act);
        fail_printed = 1'b1;
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic abort_run(string what);
        $display("ERROR at %0t: %s", $time, what);
        fail_printed = 1'b1;
        $display(">>> FAIL");
        $fatal(1);
    endtask

    // galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    task automatic draw_latency(output logic [1:0] lat);
        lfsr_q = lfsr_step(lfsr_q);
        lat[1] = lfsr_q[0];
        lfsr_q = lfsr_step(lfsr_q);
        lat[0] = lfsr_q[0];
    endtask

    //////////////////////////////////////////////////
    // instruction encoders
    //////////////////////////////////////////////////
    function automatic logic [31:0] r_type(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
                                           logic [4:0] rs1, logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(logic [6:0] op, logic [2:0] f3, logic [4:0] rd,
                                           logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] sw_word(logic [4:0] rs2, logic [11:0] imm);
        return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_type(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                           logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] j_type(logic [4:0] rd, logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    task automatic expect_store(logic [31:0] addr, logic [31:0] data);
        exp_addr[exp_count] = addr;
        exp_data[exp_count] = data;
        exp_count++;
    endtask

    task automatic load_program();
        // opcode field zero decodes as a bubble
        for (int i = 0; i < 256; i++) begin
            imem[i] = {i[24:0], 7'b0};
            dmem[i] = {i[29:0], 2'b00} ^ 32'h5a5a_0000;
        end
        // alu on constants
        imem[0]  = i_type(7'b0010011, 3'b000, 5'd1, 5'd0, 12'd5);
        imem[1]  = i_type(7'b0010011, 3'b000, 5'd2, 5'd0, 12'hffd);
        imem[2]  = r_type(7'h00, 3'b000, 5'd3, 5'd1, 5'd2);
        imem[3]  = sw_word(5'd3, 12'h100);
        imem[4]  = r_type(7'h20, 3'b000, 5'd4, 5'd1, 5'd2);
        imem[5]  = sw_word(5'd4, 12'h104);
        imem[6]  = i_type(7'b0010011, 3'b001, 5'd5, 5'd1, 12'd3);
        imem[7]  = sw_word(5'd5, 12'h108);
        imem[8]  = i_type(7'b0010011, 3'b101, 5'd6, 5'd2, 12'h401);
        imem[9]  = sw_word(5'd6, 12'h10c);
        imem[10] = i_type(7'b0010011, 3'b101, 5'd7, 5'd2, 12'd28);
        imem[11] = sw_word(5'd7, 12'h110);
        imem[12] = r_type(7'h00, 3'b010, 5'd8, 5'd2, 5'd1);
        imem[13] = sw_word(5'd8, 12'h114);
        imem[14] = r_type(7'h00, 3'b011, 5'd9, 5'd2, 5'd1);
        imem[15] = sw_word(5'd9, 12'h118);
        imem[16] = i_type(7'b0010011, 3'b100, 5'd12, 5'd1, 12'h00f);
        imem[17] = sw_word(5'd12, 12'h11c);
        imem[18] = r_type(7'h00, 3'b110, 5'd13, 5'd1, 5'd2);
        imem[19] = sw_word(5'd13, 12'h120);
        imem[20] = i_type(7'b0010011, 3'b111, 5'd14, 5'd2, 12'h0f0);
        imem[21] = sw_word(5'd14, 12'h124);
        imem[22] = r_type(7'h00, 3'b001, 5'd15, 5'd1, 5'd1);
        imem[23] = sw_word(5'd15, 12'h128);
        // lui and auipc
        imem[24] = {20'h12345, 5'd16, 7'b0110111};
        imem[25] = sw_word(5'd16, 12'h12c);
        imem[26] = {20'h00001, 5'd17, 7'b0010111};
        imem[27] = sw_word(5'd17, 12'h130);
        // taken branches, each skipping a poison store
        imem[28] = b_type(3'b000, 5'd1, 5'd1, 13'd8);
        imem[30] = b_type(3'b001, 5'd1, 5'd2, 13'd8);
        imem[32] = b_type(3'b100, 5'd2, 5'd1, 13'd8);
        imem[34] = b_type(3'b101, 5'd1, 5'd2, 13'd8);
        imem[36] = b_type(3'b110, 5'd1, 5'd2, 13'd8);
        imem[38] = b_type(3'b111, 5'd2, 5'd1, 13'd8);
        for (int i = 29; i < 40; i += 2) begin
            imem[i] = sw_word(5'd0, POISON_ADDR[11:0]);
        end
        // not taken, the following store must happen
        imem[40] = b_type(3'b000, 5'd1, 5'd2, 13'd8);
        imem[41] = sw_word(5'd1, 12'h134);
        imem[42] = b_type(3'b001, 5'd1, 5'd1, 13'd8);
        imem[43] = sw_word(5'd2, 12'h138);
        imem[44] = b_type(3'b100, 5'd1, 5'd2, 13'd8);
        imem[45] = sw_word(5'd3, 12'h13c);
        imem[46] = b_type(3'b101, 5'd2, 5'd1, 13'd8);
        imem[47] = sw_word(5'd4, 12'h140);
        imem[48] = b_type(3'b110, 5'd2, 5'd1, 13'd8);
        imem[49] = sw_word(5'd5, 12'h144);
        imem[50] = b_type(3'b111, 5'd1, 5'd2, 13'd8);
        imem[51] = sw_word(5'd12, 12'h148);
        // jumps
        imem[52] = j_type(5'd18, 21'd8);
        imem[53] = sw_word(5'd0, POISON_ADDR[11:0]);
        imem[54] = sw_word(5'd18, 12'h14c);
        imem[55] = i_type(7'b0010011, 3'b000, 5'd19, 5'd0, 12'h0e8);
        imem[56] = i_type(7'b1100111, 3'b000, 5'd20, 5'd19, 12'd0);
        imem[57] = sw_word(5'd0, POISON_ADDR[11:0]);
        imem[58] = sw_word(5'd20, 12'h150);
        // load-use with a forwarded partner
        imem[59] = i_type(7'b0010011, 3'b000, 5'd23, 5'd0, 12'd100);
        imem[60] = i_type(7'b0000011, 3'b010, 5'd22, 5'd0, 12'h104);
        imem[61] = r_type(7'h00, 3'b000, 5'd24, 5'd22, 5'd23);
        imem[62] = sw_word(5'd24, 12'h154);
        imem[63] = j_type(5'd0, 21'd0);
    endtask

    task automatic load_expected();
        exp_count = 0;
        expect_store(32'h100, 32'h0000_0002);
        expect_store(32'h104, 32'h0000_0008);
        expect_store(32'h108, 32'h0000_0028);
        expect_store(32'h10c, 32'hffff_fffe);
        expect_store(32'h110, 32'h0000_000f);
        expect_store(32'h114, 32'h0000_0001);
        expect_store(32'h118, 32'h0000_0000);
        expect_store(32'h11c, 32'h0000_000a);
        expect_store(32'h120, 32'hffff_fffd);
        expect_store(32'h124, 32'h0000_00f0);
        expect_store(32'h128, 32'h0000_00a0);
        expect_store(32'h12c, 32'h1234_5000);
        expect_store(32'h130, 32'h0000_1068);
        expect_store(32'h134, 32'h0000_0005);
        expect_store(32'h138, 32'hffff_fffd);
        expect_store(32'h13c, 32'h0000_0002);
        expect_store(32'h140, 32'h0000_0008);
        expect_store(32'h144, 32'h0000_0028);
        expect_store(32'h148, 32'h0000_000a);
        expect_store(32'h14c, 32'h0000_00d4);
        expect_store(32'h150, 32'h0000_00e4);
        expect_store(32'h154, 32'h0000_006c);
    endtask

    //////////////////////////////////////////////////
    // store checks
    //////////////////////////////////////////////////
    assert property (@(posedge clk_i) disable iff (reset_i)
        ram_req_o && ram_we_o && ram_ok_i |-> store_idx < NUM_STORES &&
                                              ram_addr_o == exp_addr[store_idx])
        else flag_mismatch("store address", exp_addr[store_idx], $sampled(ram_addr_o));

    assert property (@(posedge clk_i) disable iff (reset_i)
        ram_req_o && ram_we_o && ram_ok_i |-> ram_wdata_o == exp_data[store_idx])
        else flag_mismatch("store data", exp_data[store_idx], $sampled(ram_wdata_o));

    assert property (@(posedge clk_i) disable iff (reset_i)
        ram_req_o |-> ram_addr_o != POISON_ADDR)
        else abort_run("a store that should have been skipped reached the data port");

    //////////////////////////////////////////////////
    // memory models, driven on the falling edge
    //////////////////////////////////////////////////
    always @(negedge clk_i) begin
        if (!reset_i) begin
            if (rom_ok_i) begin
                rom_ok_i = 1'b0;
                rom_busy = 1'b0;
            end else if (rom_req_o) begin
                if (!rom_busy) begin
                    rom_busy = 1'b1;
                    draw_latency(rom_wait);
                end
                if (rom_wait == 2'd0) begin
                    rom_ok_i    = 1'b1;
                    rom_rdata_i = imem[rom_addr_o[9:2]];
                end else begin
                    rom_wait = rom_wait - 2'd1;
                end
            end
            if (ram_ok_i) begin
                if (ram_ack_store) begin
                    store_idx++;
                end
                ram_ok_i = 1'b0;
                ram_busy = 1'b0;
            end else if (ram_req_o) begin
                if (!ram_busy) begin
                    ram_busy = 1'b1;
                    draw_latency(ram_wait);
                end
                if (ram_wait == 2'd0) begin
                    ram_ok_i      = 1'b1;
                    ram_ack_store = ram_we_o;
                    if (ram_we_o) begin
                        dmem[ram_addr_o[9:2]] = ram_wdata_o;
                    end else begin
                        ram_rdata_i = dmem[ram_addr_o[9:2]];
                    end
                end else begin
                    ram_wait = ram_wait - 2'd1;
                end
            end
        end
    end

    initial begin
        reset_i       = 1'b1;
        rom_ok_i      = 1'b0;
        rom_rdata_i   = '0;
        ram_ok_i      = 1'b0;
        ram_rdata_i   = '0;
        rom_busy      = 1'b0;
        rom_wait      = '0;
        ram_busy      = 1'b0;
        ram_wait      = '0;
        ram_ack_store = 1'b0;
        store_idx     = 0;
        lfsr_q        = 32'h7c6c;
        passed        = 1'b0;
        fail_printed  = 1'b0;
        load_program();
        load_expected();
        repeat (RESET_CYCLES) @(posedge clk_i);
        @(negedge clk_i);
        reset_i = 1'b0;
        wait (store_idx == NUM_STORES);
        repeat (4) @(negedge clk_i);
        passed = 1'b1;
        $display(">>> PASS");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        abort_run("watchdog expired before all expected stores were seen");
    end

    // run stopped by a bound assertion
    final begin
        if (!passed && !fail_printed) begin
            $display(">>> FAIL");
        end
    end

endmodule

/* sources.f */
rtl/rv_core_pkg.sv
rtl/pipe_stage.sv
rtl/fetch_unit.sv
rtl/decoder.sv
rtl/regfile_bypass.sv
rtl/execute_unit.sv
rtl/rv_core.sv
verification/rv_core_props.sv
verification/tb_rv_core.sv

/* Makefile */
TOP = tb_rv_core

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f sources.f

run: compile
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q '^>>> PASS$$'

clean:
	rm -rf obj_dir
